// File: sources.f
src/fetch_pkg.sv
src/imem_if.sv
src/instr_mem.sv
src/fetch_unit.sv
src/instr_decode.sv
src/fetch_top.sv
verification/fetch_asserts.sv
verification/fetch_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module fetch_tb -o fetch_sim

output=$(./obj_dir/fetch_sim 2>&1 || true)
echo "$output"

# Exit status of grep decides pass or fail.
echo "$output" | grep -q "Result: PASSED"

// File: verification/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

    typedef struct packed {
        instr_class_e cls;
        reg_index_t   rd;
        reg_index_t   rs1;
        reg_index_t   rs2;
        word_t        imm;
    } decoded_t;

    localparam int      EXPECTED_INSTR = 9 + 7 + 4 + 4 + 8;  // Outputs of all tests.
    localparam int      IDLE_CYCLES    = 50;
    localparam opcode_t BODY_OPS [4]   = '{OP_IMM, OP_LOAD, OP_STORE, OP_REG};
    localparam opcode_t IMM_OPS [6]    = '{OP_LUI, OP_AUIPC, OP_STORE, OP_IMM, OP_LOAD, OP_BRANCH};

    logic         i_clock;
    logic         i_rst_n;
    logic         i_load_we;
    mem_index_t   i_load_index;
    word_t        i_load_data;
    logic         i_redirect;
    addr_t        i_redirect_pc;
    logic         o_dec_valid;
    addr_t        o_pc;
    word_t        o_instruction;
    instr_class_e o_class;
    reg_index_t   o_rd;
    reg_index_t   o_rs1;
    reg_index_t   o_rs2;
    word_t        o_imm;

    word_t image [MEM_WORDS];  // Copy of what the load port wrote.
    addr_t exp_pc [$];
    word_t exp_word [$];
    string test_name;
    int    seed;
    int    errors;
    int    checks;
    int    tests;
    int    errors_before;
    int    target;

    fetch_top fetch_top_i (.*);

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    function automatic word_t sign_extend(input word_t value, input int top);
        return value[top] ? (value | ~((32'd2 << top) - 32'd1)) : value;
    endfunction

    function automatic decoded_t ref_decode(input word_t w);
        decoded_t d;
        d.rd  = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.cls = CLASS_OTHER;
        d.imm = '0;
        case (w[6:0])
            OP_IMM, OP_REG:   d.cls = CLASS_ALU;
            OP_LOAD:          d.cls = CLASS_LOAD;
            OP_STORE:         d.cls = CLASS_STORE;
            OP_BRANCH:        d.cls = CLASS_BRANCH;
            OP_JAL, OP_JALR:  d.cls = CLASS_JUMP;
            OP_LUI, OP_AUIPC: d.cls = CLASS_UPPER;
            default:          d.cls = CLASS_OTHER;
        endcase
        case (w[6:0])
            OP_IMM, OP_LOAD, OP_JALR: d.imm = sign_extend({20'b0, w[31:20]}, 11);
            OP_STORE:  d.imm = sign_extend({20'b0, w[31:25], w[11:7]}, 11);
            OP_BRANCH: d.imm = sign_extend({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 12);
            OP_JAL:    d.imm = sign_extend({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 20);
            OP_LUI, OP_AUIPC: d.imm = {w[31:12], 12'b0};
            default:   d.imm = '0;  // R-type and unknown.
        endcase
        return d;
    endfunction

    function automatic logic stops_fetch(input word_t w);
        return (w[6:0] == OP_BRANCH) || (w[6:0] == OP_JAL) || (w[6:0] == OP_JALR);
    endfunction

    task automatic check_field(input string field, input word_t expected, input word_t actual);
        checks++;
        assert (expected == actual) else begin
            $display("MISMATCH %s %s expected %h actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_output();
        addr_t    pc;
        word_t    word;
        decoded_t want;
        checks++;
        assert (exp_pc.size() != 0) else begin
            $display("ERROR %s: output at pc %h where none was expected", test_name, o_pc);
            errors++;
        end
        if (exp_pc.size() != 0) begin
            pc   = exp_pc.pop_front();
            word = exp_word.pop_front();
            want = ref_decode(word);
            check_field("pc", pc, o_pc);
            check_field("instruction", word, o_instruction);
            check_field("class", 32'(want.cls), 32'(o_class));
            check_field("rd", 32'(want.rd), 32'(o_rd));
            check_field("rs1", 32'(want.rs1), 32'(o_rs1));
            check_field("rs2", 32'(want.rs2), 32'(o_rs2));
            check_field("imm", want.imm, o_imm);
        end
    endtask

    always @(negedge i_clock) begin
        if (o_dec_valid === 1'b1) begin
            compare_output();
        end
    end

    // Called 1 ns after a rising edge, returns the same way.
    task automatic place_word(input int index, input opcode_t opcode, input logic negative);
        word_t w;
        w      = $random(seed);
        w[6:0] = opcode;
        if (negative) begin
            w[31] = 1'b1;
        end
        image[index] = w;
        i_load_we    = 1'b1;
        i_load_index = mem_index_t'(index);
        i_load_data  = w;
        @(posedge i_clock);
        #1;
        i_load_we = 1'b0;
    endtask

    task automatic place_body(input int start, input int count);
        for (int i = 0; i < count; i++) begin
            place_word(start + i, BODY_OPS[i % 4], 1'b0);
        end
    endtask

    // Model PC steps by four until a control transfer.
    task automatic expect_run(input addr_t start_pc);
        addr_t pc;
        logic  done;
        pc   = start_pc;
        done = 1'b0;
        while (!done) begin
            exp_pc.push_back(pc);
            exp_word.push_back(image[pc[9:2]]);
            done = stops_fetch(image[pc[9:2]]);
            pc   = pc + 32'd4;
        end
    endtask

    task automatic send_redirect(input addr_t pc);
        i_redirect    = 1'b1;
        i_redirect_pc = pc;
        @(posedge i_clock);
        #1;
        i_redirect = 1'b0;
    endtask

    task automatic drain_and_idle();
        while (exp_pc.size() != 0) begin
            @(posedge i_clock);
            #1;
        end
        repeat (IDLE_CYCLES) @(posedge i_clock);  // Stalled, nothing may come out.
        #1;
    endtask

    task automatic run_from(input addr_t pc);
        expect_run(pc);
        send_redirect(pc);
        drain_and_idle();
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = errors;
    endtask

    task automatic finish_test();
        tests++;
        $display("%s: %s, %0d errors", test_name,
                 (errors == errors_before) ? "ok" : "failed", errors - errors_before);
    endtask

    initial begin
        repeat (100 * EXPECTED_INSTR + 200) @(posedge i_clock);
        $display("Watchdog expired in test %s, outputs still missing", test_name);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed          = 89;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        i_rst_n       = 1'b0;
        i_load_we     = 1'b0;
        i_load_index  = '0;
        i_load_data   = '0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        repeat (10) @(posedge i_clock);
        #1;
        i_rst_n = 1'b1;

        start_test("reset_state");
        repeat (30) begin
            @(posedge i_clock);
            #1;
            checks++;
            assert (o_dec_valid === 1'b0) else begin
                $display("ERROR %s: decoded output valid before any redirect", test_name);
                errors++;
            end
        end
        finish_test();

        start_test("straight_line");
        place_body(16, 8);
        place_word(24, OP_BRANCH, 1'b0);
        run_from(32'd64);
        finish_test();

        start_test("stall_on_control");
        place_body(32, 3);
        place_word(35, OP_JAL, 1'b0);
        run_from(32'd128);
        place_body(40, 2);
        place_word(42, OP_JALR, 1'b0);
        run_from(32'd160);
        finish_test();

        start_test("redirect_resume");
        target = 128 + int'({$random(seed)} % 64);
        place_body(target, 3);
        place_word(target + 3, OP_BRANCH, 1'b0);
        run_from(addr_t'(target * 4));
        finish_test();

        start_test("redirect_in_flight");
        place_word(100, OP_IMM, 1'b0);  // Its fetch gets aborted.
        place_body(104, 3);
        place_word(107, OP_BRANCH, 1'b0);
        expect_run(32'd416);
        send_redirect(32'd400);
        send_redirect(32'd416);
        drain_and_idle();
        finish_test();

        start_test("imm_formats");
        for (int i = 0; i < 6; i++) begin
            place_word(80 + i, IMM_OPS[i], 1'b1);
        end
        run_from(32'd320);
        place_word(88, OP_JAL, 1'b1);
        run_from(32'd352);
        place_word(90, OP_JALR, 1'b1);
        run_from(32'd360);
        finish_test();

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verification/fetch_asserts.sv
`timescale 1ns/100ps

module fetch_asserts import fetch_pkg::*; (
    input logic         i_clock,
    input logic         i_rst_n,
    input logic         i_redirect,
    input logic         i_request,
    input logic         i_ready,
    input addr_t        i_address,
    input logic         i_valid,
    input fetch_state_e i_state
);

    // Memory sees one address per access.
    address_stable: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_request && !i_ready && !i_redirect |=> $stable(i_address)
    ) else $error("fetch address changed while a request was pending");

    valid_single_cycle: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_valid |=> !i_valid
    ) else $error("fetch valid pulse lasted more than one cycle");

    stall_holds_request_low: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (i_state == FETCH_STALL) && !i_redirect |=> !i_request
    ) else $error("request raised while stalled without a redirect");

endmodule

bind fetch_unit fetch_asserts fetch_asserts_i (
    .i_clock    (i_clock),
    .i_rst_n    (i_rst_n),
    .i_redirect (i_redirect),
    .i_request  (request_q),
    .i_ready    (mem.ready),
    .i_address  (address_q),
    .i_valid    (o_valid),
    .i_state    (state_q)
);

// File: src/fetch_top.sv
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
    input  logic         i_clock,
    input  logic         i_rst_n,
    input  logic         i_load_we,
    input  mem_index_t   i_load_index,
    input  word_t        i_load_data,
    input  logic         i_redirect,
    input  addr_t        i_redirect_pc,
    output logic         o_dec_valid,
    output addr_t        o_pc,
    output word_t        o_instruction,
    output instr_class_e o_class,
    output reg_index_t   o_rd,
    output reg_index_t   o_rs1,
    output reg_index_t   o_rs2,
    output word_t        o_imm
);

    imem_if imem_bus ();

    logic  fetch_valid;
    word_t fetch_instruction;
    addr_t fetch_pc;

    instr_mem instr_mem_i (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_load_we    (i_load_we),
        .i_load_index (i_load_index),
        .i_load_data  (i_load_data),
        .mem          (imem_bus.memory)
    );

    fetch_unit fetch_unit_i (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .mem           (imem_bus.fetcher),
        .o_valid       (fetch_valid),
        .o_instruction (fetch_instruction),
        .o_pc          (fetch_pc)
    );

    instr_decode instr_decode_i (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_valid       (fetch_valid),
        .i_instruction (fetch_instruction),
        .i_pc          (fetch_pc),
        .o_dec_valid   (o_dec_valid),
        .o_pc          (o_pc),
        .o_instruction (o_instruction),
        .o_class       (o_class),
        .o_rd          (o_rd),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_imm         (o_imm)
    );

endmodule

// File: src/instr_decode.sv
`timescale 1ns/100ps

module instr_decode import fetch_pkg::*; (
    input  logic         i_clock,
    input  logic         i_rst_n,
    input  logic         i_valid,
    input  word_t        i_instruction,
    input  addr_t        i_pc,
    output logic         o_dec_valid,
    output addr_t        o_pc,
    output word_t        o_instruction,
    output instr_class_e o_class,
    output reg_index_t   o_rd,
    output reg_index_t   o_rs1,
    output reg_index_t   o_rs2,
    output word_t        o_imm
);

    opcode_t      opcode;
    instr_class_e dec_class;
    word_t        dec_imm;
    word_t        w;

    assign w      = i_instruction;
    assign opcode = w[6:0];

    always_comb begin
        case (opcode)
            OP_IMM, OP_REG:    dec_class = CLASS_ALU;
            OP_LOAD:           dec_class = CLASS_LOAD;
            OP_STORE:          dec_class = CLASS_STORE;
            OP_BRANCH:         dec_class = CLASS_BRANCH;
            OP_JAL, OP_JALR:   dec_class = CLASS_JUMP;
            OP_LUI, OP_AUIPC:  dec_class = CLASS_UPPER;
            default:           dec_class = CLASS_OTHER;
        endcase
    end

    // Sign-extended immediate per format.
    always_comb begin
        case (opcode)
            OP_LOAD, OP_IMM, OP_JALR: begin
                dec_imm = {{20{w[31]}}, w[31:20]};  // I-type.
            end
            OP_STORE: begin
                dec_imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OP_BRANCH: begin
                dec_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                dec_imm = {w[31:12], 12'b0};
            end
            OP_JAL: begin
                dec_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                dec_imm = '0;  // R-type and unknown.
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_dec_valid <= 1'b0;
        end else begin
            o_dec_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_pc          <= i_pc;
            o_instruction <= w;
            o_class       <= dec_class;
            o_rd          <= w[11:7];
            o_rs1         <= w[19:15];
            o_rs2         <= w[24:20];
            o_imm         <= dec_imm;
        end
    end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import fetch_pkg::*; (
    input  logic    i_clock,
    input  logic    i_rst_n,
    input  logic    i_redirect,
    input  addr_t   i_redirect_pc,
    imem_if.fetcher mem,
    output logic    o_valid,
    output word_t   o_instruction,
    output addr_t   o_pc
);

    fetch_state_e state_q;
    addr_t        pc_q;
    addr_t        address_q;
    logic         request_q;
    logic         restart_q;
    logic         issue;
    logic         fetch_done;

    // Redirect overrides both of these.
    assign issue      = (state_q == FETCH_ISSUE) && !i_redirect;
    assign fetch_done = (state_q == FETCH_WAIT) && mem.ready && !i_redirect;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state_q   <= FETCH_STALL;
            pc_q      <= RESET_PC;
            request_q <= 1'b0;
            restart_q <= 1'b0;
            o_valid   <= 1'b0;
        end else begin
            restart_q <= 1'b0;
            o_valid   <= 1'b0;
            if (i_redirect) begin
                pc_q      <= i_redirect_pc;
                request_q <= 1'b1;
                restart_q <= 1'b1;  // Memory aborts anything in flight.
                state_q   <= FETCH_WAIT;
            end else begin
                case (state_q)
                    FETCH_ISSUE: begin
                        request_q <= 1'b1;
                        state_q   <= FETCH_WAIT;
                    end
                    FETCH_WAIT: begin
                        if (fetch_done) begin
                            request_q <= 1'b0;
                            o_valid   <= 1'b1;
                            pc_q      <= pc_q + 32'd4;
                            if (is_control_transfer(mem.data)) begin
                                state_q <= FETCH_STALL;  // Wait for the branch unit.
                            end else begin
                                state_q <= FETCH_ISSUE;
                            end
                        end
                    end
                    default: begin
                        state_q <= FETCH_STALL;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_redirect) begin
            address_q <= i_redirect_pc;
        end else if (issue) begin
            address_q <= pc_q;
        end
        if (fetch_done) begin
            o_instruction <= mem.data;
            o_pc          <= pc_q;
        end
    end

    assign mem.request = request_q;
    assign mem.restart = restart_q;
    assign mem.address = address_q;

endmodule

// File: src/instr_mem.sv
`timescale 1ns/100ps

module instr_mem import fetch_pkg::*; (
    input  logic        i_clock,
    input  logic        i_rst_n,
    input  logic        i_load_we,
    input  mem_index_t  i_load_index,
    input  word_t       i_load_data,
    imem_if.memory      mem
);

    word_t             mem_q [MEM_WORDS];
    logic [3:0]        lfsr_q;
    logic              busy_q;
    logic              ready_q;
    word_t             data_q;
    logic [WAIT_W-1:0] wait_cnt_q;
    logic [WAIT_W-1:0] wait_draw;
    logic [WAIT_W-1:0] wait_left;
    logic              start;
    logic              fire;
    mem_index_t        fetch_index;

    assign fetch_index = mem.address[9:2];  // Word index.
    assign wait_draw   = lfsr_q[WAIT_W-1:0];

    // A fresh request is not taken in the cycle its answer is out.
    assign start     = mem.restart || (mem.request && !busy_q && !ready_q);
    assign wait_left = start ? wait_draw : wait_cnt_q;
    assign fire      = (start || busy_q) && (wait_left == '0);

    always_ff @(posedge i_clock) begin
        if (i_load_we) begin
            mem_q[i_load_index] <= i_load_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            lfsr_q     <= 4'b0001;
            busy_q     <= 1'b0;
            ready_q    <= 1'b0;
            wait_cnt_q <= '0;
        end else begin
            lfsr_q  <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};  // x^4 + x^3 + 1.
            ready_q <= 1'b0;
            if (fire) begin
                ready_q <= 1'b1;
                busy_q  <= 1'b0;
            end else if (start || busy_q) begin
                busy_q     <= 1'b1;
                wait_cnt_q <= wait_left - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (fire) begin
            data_q <= mem_q[fetch_index];
        end
    end

    // Answer for the old address is dropped on restart.
    assign mem.ready = ready_q && !mem.restart;
    assign mem.data  = data_q;

endmodule

// File: src/imem_if.sv
`timescale 1ns/100ps

interface imem_if import fetch_pkg::*; ();

    logic  request;   // Level, held until ready.
    logic  restart;   // One-cycle pulse with a new address.
    addr_t address;
    logic  ready;     // One-cycle pulse, data valid.
    word_t data;

    modport fetcher (
        output request,
        output restart,
        output address,
        input  ready,
        input  data
    );

    modport memory (
        input  request,
        input  restart,
        input  address,
        output ready,
        output data
    );

endinterface

// File: src/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  mem_index_t;
    typedef logic [4:0]  reg_index_t;
    typedef logic [6:0]  opcode_t;

    localparam int    MEM_WORDS = 256;
    localparam addr_t RESET_PC  = 32'h0000_0000;
    localparam int    MAX_WAIT  = 3;
    localparam int    WAIT_W    = $clog2(MAX_WAIT + 1);  // Wait counter width.

    // RV32I base opcodes.
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JUMP,
        CLASS_UPPER,
        CLASS_OTHER
    } instr_class_e;

    typedef enum logic [1:0] {
        FETCH_ISSUE,
        FETCH_WAIT,
        FETCH_STALL
    } fetch_state_e;

    // True for words that change the flow of control.
    function automatic logic is_control_transfer(input word_t word);
        opcode_t opcode;
        opcode = word[6:0];
        return (opcode == OP_BRANCH) || (opcode == OP_JAL) || (opcode == OP_JALR);
    endfunction

endpackage
